// File: design/robPkg.sv
package robPkg;

    // --------------------
    // buffer geometry

    localparam int ROB_SIZE       = 16;
    localparam int ROB_IDX_W      = 4;     // log2 of ROB_SIZE
    localparam int DISPATCH_WIDTH = 2;
    localparam int COMMIT_WIDTH   = 2;     // also the walk width
    localparam int WB_WIDTH       = 2;
    localparam int ARCH_REG_W     = 5;
    localparam int PHYS_REG_W     = 6;

    localparam int PTR_W = ROB_IDX_W + 1;  // index plus wrap bit
    localparam int OCC_W = $clog2(ROB_SIZE + 1);
    localparam int CNT_W = $clog2(((DISPATCH_WIDTH > COMMIT_WIDTH) ?
                                   DISPATCH_WIDTH : COMMIT_WIDTH) + 1);

    // --------------------
    // shared types

    // the wrap bit flips each lap so that two indices can be ordered by age
    typedef struct packed {
        logic                 dir;
        logic [ROB_IDX_W-1:0] idx;
    } robIdx;

    typedef struct packed {
        logic                  writesReg;
        logic [ARCH_REG_W-1:0] archDest;
        logic [PHYS_REG_W-1:0] physDest;
    } robEntry;

    typedef enum logic {
        IDLE,
        WALK
    } robState;

endpackage

// File: design/robIf.sv
`timescale 1ns/1ps

// --------------------
// dispatch write ports

interface robWriteIf;
    import robPkg::*;

    logic [DISPATCH_WIDTH-1:0]                en;
    logic [DISPATCH_WIDTH-1:0][ROB_IDX_W-1:0] addr;     // slot i lands at tail + i
    robEntry [DISPATCH_WIDTH-1:0]             entry;    // fed straight from the dispatch ports

    modport ctrl(
        output en,
        output addr
    );

    modport store(
        input en,
        input addr,
        input entry
    );
endinterface

// --------------------
// commit and walk read ports

interface robReadIf;
    import robPkg::*;

    logic [COMMIT_WIDTH-1:0][ROB_IDX_W-1:0] addr;   // head side in IDLE, tail side in WALK
    robEntry [COMMIT_WIDTH-1:0]             entry;
    logic [COMMIT_WIDTH-1:0]                done;

    modport ctrl(
        output addr
    );

    // entry comes from the RAM and done from the completion table
    modport store(
        input  addr,
        output entry,
        output done
    );

    modport monitor(
        input addr,
        input entry,
        input done
    );
endinterface

// File: design/robEntryRam.sv
`timescale 1ns/1ps

module robEntryRam (
    input  logic      clk,
    input  logic      reset,
    robWriteIf.store  write,
    robReadIf.store   read
);
    import robPkg::*;

    robEntry mem [ROB_SIZE];

    // --------------------
    // write side

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ROB_SIZE; i++) begin
                mem[i] <= '0;                   // keeps commit and walk payloads known
            end
        end else begin
            for (int w = 0; w < DISPATCH_WIDTH; w++) begin
                if (write.en[w]) begin
                    mem[write.addr[w]] <= write.entry[w];
                end
            end
        end
    end

    // --------------------
    // read side

    // dispatch slots always target distinct addresses, so the write ports never collide
    for (genvar r = 0; r < COMMIT_WIDTH; r++) begin : gRead
        assign read.entry[r] = mem[read.addr[r]];   // asynchronous read
    end

endmodule

// File: design/robCompletionTable.sv
`timescale 1ns/1ps

module robCompletionTable (
    input  logic                                   clk,
    input  logic                                   reset,
    robWriteIf.store                               write,
    input  logic [robPkg::WB_WIDTH-1:0]            wbEn,
    input  robPkg::robIdx [robPkg::WB_WIDTH-1:0]   wbIdx,
    robReadIf.store                                read
);
    import robPkg::*;

    logic [ROB_SIZE-1:0] doneBits;

    // --------------------
    // update

    always_ff @(posedge clk) begin
        if (reset) begin
            doneBits <= '0;
        end else begin
            for (int w = 0; w < DISPATCH_WIDTH; w++) begin
                if (write.en[w]) begin
                    doneBits[write.addr[w]] <= 1'b0;    // fresh entry is not complete yet
                end
            end
            // a writeback never targets an entry dispatched at the same edge
            for (int b = 0; b < WB_WIDTH; b++) begin
                if (wbEn[b]) begin
                    doneBits[wbIdx[b].idx] <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // lookup at the read positions

    always_comb begin
        for (int r = 0; r < COMMIT_WIDTH; r++) begin
            read.done[r] = doneBits[read.addr[r]];
        end
    end

endmodule

// File: design/robCommitSelect.sv
`timescale 1ns/1ps

module robCommitSelect (
    input  logic [robPkg::OCC_W-1:0]        occupancy,
    robReadIf.monitor                       read,
    output logic [robPkg::COMMIT_WIDTH-1:0] commitMask,
    output logic [robPkg::CNT_W-1:0]        commitNum
);
    import robPkg::*;

    logic [CNT_W-1:0]        candNum;
    logic [COMMIT_WIDTH-1:0] candMask;
    logic                    olderDone;     // every older candidate is complete

    // only occupied slots at the head may commit
    assign candNum = (occupancy < OCC_W'(COMMIT_WIDTH)) ? CNT_W'(occupancy) :
                                                          CNT_W'(COMMIT_WIDTH);

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            candMask[i] = i < int'(candNum);
        end
    end

    // prefix rule, a slot stops everything younger than itself
    always_comb begin
        olderDone = 1'b1;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commitMask[i] = olderDone & candMask[i] & read.done[i];
            olderDone     = commitMask[i];
        end
    end

    always_comb begin
        commitNum = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commitNum = commitNum + CNT_W'(commitMask[i]);
        end
    end

endmodule

// File: design/robControl.sv
`timescale 1ns/1ps

module robControl (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [robPkg::DISPATCH_WIDTH-1:0]           dispEn,
    input  logic                                        redirectEn,
    input  robPkg::robIdx                               redirectIdx,
    input  logic [robPkg::COMMIT_WIDTH-1:0]             commitMask,
    input  logic [robPkg::CNT_W-1:0]                    commitNum,
    robWriteIf.ctrl                                     write,
    robReadIf.ctrl                                      read,
    output logic [robPkg::OCC_W-1:0]                    occupancy,
    output robPkg::robIdx [robPkg::DISPATCH_WIDTH-1:0]  dispIdx,
    output logic [robPkg::COMMIT_WIDTH-1:0]             commitEn,
    output logic [robPkg::COMMIT_WIDTH-1:0]             walkEn,
    output logic                                        walking,
    output logic [robPkg::CNT_W-1:0]                    creditReturn
);
    import robPkg::*;

    robState                   state;
    robState                   nextState;
    logic [PTR_W-1:0]          head;
    logic [PTR_W-1:0]          tail;
    logic [PTR_W-1:0]          redirectPtr;
    logic [OCC_W-1:0]          walkRemain;      // squashed entries not yet shown
    logic [OCC_W-1:0]          nextRemain;
    logic [OCC_W-1:0]          squashNum;
    logic [OCC_W-1:0]          walkLeft;
    logic [CNT_W-1:0]          walkStep;
    logic [CNT_W-1:0]          commitCnt;       // entries on commitEn this cycle
    logic [CNT_W-1:0]          walkCnt;         // entries on walkEn this cycle
    logic [CNT_W-1:0]          nextCommitCnt;
    logic [CNT_W-1:0]          nextWalkCnt;
    logic [COMMIT_WIDTH-1:0]   nextCommitEn;
    logic [DISPATCH_WIDTH-1:0] dispFire;
    logic [CNT_W-1:0]          dispCnt;

    function automatic logic [COMMIT_WIDTH-1:0] countMask(input logic [CNT_W-1:0] cnt);
        logic [COMMIT_WIDTH-1:0] mask;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            mask[i] = i < int'(cnt);
        end
        return mask;
    endfunction

    // --------------------
    // dispatch side

    assign redirectPtr = redirectIdx;
    assign dispFire    = (state == IDLE && !redirectEn) ? dispEn : '0;
    assign walking     = state == WALK;

    always_comb begin
        dispCnt = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dispCnt = dispCnt + CNT_W'(dispFire[i]);
        end
    end

    always_comb begin
        write.en = dispFire;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            write.addr[i] = tail[ROB_IDX_W-1:0] + ROB_IDX_W'(i);
            dispIdx[i]    = tail + PTR_W'(i);               // wrap bit carries into dir
        end
    end

    // youngest first while walking, oldest first otherwise
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (state == WALK) begin
                read.addr[i] = tail[ROB_IDX_W-1:0] - ROB_IDX_W'(i + 1);
            end else begin
                read.addr[i] = head[ROB_IDX_W-1:0] + ROB_IDX_W'(i);
            end
        end
    end

    // --------------------
    // next output beat

    assign squashNum = tail - redirectPtr;                 // tail back to redirectIdx inclusive
    assign walkLeft  = (state == WALK) ? walkRemain : squashNum;
    assign walkStep  = (walkLeft < OCC_W'(COMMIT_WIDTH)) ? CNT_W'(walkLeft) :
                                                           CNT_W'(COMMIT_WIDTH);

    always_comb begin
        nextState     = state;
        nextRemain    = walkRemain;
        nextWalkCnt   = '0;
        nextCommitCnt = '0;
        nextCommitEn  = '0;
        case (state)
            IDLE: begin
                if (redirectEn) begin
                    nextState   = WALK;
                    nextWalkCnt = walkStep;
                    nextRemain  = walkLeft - OCC_W'(walkStep);
                end else if (commitCnt == '0) begin
                    // the read ports still hold a committing pair, so select every other cycle
                    nextCommitEn  = commitMask;
                    nextCommitCnt = commitNum;
                end
            end
            WALK: begin
                if (walkRemain == '0) begin
                    nextState = IDLE;
                end else begin
                    nextWalkCnt = walkStep;
                    nextRemain  = walkRemain - OCC_W'(walkStep);
                end
            end
        endcase
    end

    // --------------------
    // state and outputs

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            head         <= '0;
            tail         <= '0;
            occupancy    <= '0;
            walkRemain   <= '0;
            commitCnt    <= '0;
            walkCnt      <= '0;
            commitEn     <= '0;
            walkEn       <= '0;
            creditReturn <= '0;
        end else begin
            state        <= nextState;
            head         <= head + PTR_W'(commitCnt);       // frees the pair shown this cycle
            tail         <= tail + PTR_W'(dispCnt) - PTR_W'(walkCnt);
            occupancy    <= occupancy + OCC_W'(dispCnt) - OCC_W'(commitCnt) - OCC_W'(walkCnt);
            walkRemain   <= nextRemain;
            commitCnt    <= nextCommitCnt;
            walkCnt      <= nextWalkCnt;
            commitEn     <= nextCommitEn;
            walkEn       <= countMask(nextWalkCnt);
            creditReturn <= nextCommitCnt + nextWalkCnt;    // never both in one beat
        end
    end

endmodule

// File: design/robTop.sv
`timescale 1ns/1ps

module robTop (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [robPkg::DISPATCH_WIDTH-1:0]            dispEn,
    input  robPkg::robEntry [robPkg::DISPATCH_WIDTH-1:0] dispEntry,
    output robPkg::robIdx [robPkg::DISPATCH_WIDTH-1:0]   dispIdx,
    input  logic [robPkg::WB_WIDTH-1:0]                  wbEn,
    input  robPkg::robIdx [robPkg::WB_WIDTH-1:0]         wbIdx,
    input  logic                                         redirectEn,
    input  robPkg::robIdx                                redirectIdx,
    output logic [robPkg::COMMIT_WIDTH-1:0]              commitEn,
    output robPkg::robEntry [robPkg::COMMIT_WIDTH-1:0]   commitEntry,
    output logic [robPkg::COMMIT_WIDTH-1:0]              walkEn,
    output robPkg::robEntry [robPkg::COMMIT_WIDTH-1:0]   walkEntry,
    output logic                                         walking,
    output logic [robPkg::CNT_W-1:0]                     creditReturn
);
    import robPkg::*;

    logic [OCC_W-1:0]        occupancy;
    logic [COMMIT_WIDTH-1:0] commitMask;
    logic [CNT_W-1:0]        commitNum;

    robWriteIf wrIf();
    robReadIf  rdIf();

    assign wrIf.entry  = dispEntry;
    // commit and walk share the read ports, their enables tell them apart
    assign commitEntry = rdIf.entry;
    assign walkEntry   = rdIf.entry;

    // --------------------
    // control and datapath

    robControl uControl (
        .clk          (clk),
        .reset        (reset),
        .dispEn       (dispEn),
        .redirectEn   (redirectEn),
        .redirectIdx  (redirectIdx),
        .commitMask   (commitMask),
        .commitNum    (commitNum),
        .write        (wrIf.ctrl),
        .read         (rdIf.ctrl),
        .occupancy    (occupancy),
        .dispIdx      (dispIdx),
        .commitEn     (commitEn),
        .walkEn       (walkEn),
        .walking      (walking),
        .creditReturn (creditReturn)
    );

    robEntryRam uEntryRam (
        .clk   (clk),
        .reset (reset),
        .write (wrIf.store),
        .read  (rdIf.store)
    );

    robCompletionTable uCompletion (
        .clk   (clk),
        .reset (reset),
        .write (wrIf.store),
        .wbEn  (wbEn),
        .wbIdx (wbIdx),
        .read  (rdIf.store)
    );

    robCommitSelect uCommitSelect (
        .occupancy  (occupancy),
        .read       (rdIf.monitor),
        .commitMask (commitMask),
        .commitNum  (commitNum)
    );

endmodule

// File: test/robTop_props.sv
`timescale 1ns/1ps

module robTopProps (
    input logic                                 clk,
    input logic                                 reset,
    input logic [robPkg::DISPATCH_WIDTH-1:0]    dispEn,
    input logic [robPkg::COMMIT_WIDTH-1:0]      commitEn,
    input logic [robPkg::COMMIT_WIDTH-1:0]      walkEn,
    input logic                                 walking,
    input logic [robPkg::CNT_W-1:0]             creditReturn,
    input robPkg::robState                      state
);
    import robPkg::*;

    // --------------------
    // credit rule

    creditCount: assert property (@(posedge clk) disable iff (reset)
        creditReturn == CNT_W'($countones(commitEn) + $countones(walkEn)))
        else $error("creditReturn differs from the number of freed entries");

    // --------------------
    // walk rules

    noCommitInWalk: assert property (@(posedge clk) disable iff (reset)
        (state == WALK) |-> commitEn == '0)
        else $error("commit shown while walking");

    noDispatchInWalk: assert property (@(posedge clk) disable iff (reset)
        walking |-> dispEn == '0)
        else $error("dispatch issued while walking");

endmodule

bind robTop robTopProps uProps (
    .clk          (clk),
    .reset        (reset),
    .dispEn       (dispEn),
    .commitEn     (commitEn),
    .walkEn       (walkEn),
    .walking      (walking),
    .creditReturn (creditReturn),
    .state        (uControl.state)
);

// File: test/robTb.sv
`timescale 1ns/1ps

module robTb;
    import robPkg::*;

    localparam int TIMEOUT   = 300;
    localparam int OP_DISP   = 0;
    localparam int OP_WBRAND = 1;
    localparam int OP_WBALL  = 2;
    localparam int OP_REDIR  = 3;
    localparam int OP_IDLE   = 4;

    typedef struct packed {
        int op;
        int count;
        int offset;     // redirect position counted from the oldest entry
    } stepRow;

    localparam int NUM_STEPS = 10;
    localparam stepRow STEPS [NUM_STEPS] = '{
        '{OP_DISP, 16, 0}, '{OP_IDLE, 6, 0}, '{OP_WBRAND, 16, 0}, '{OP_WBALL, 0, 0},
        '{OP_DISP, 8, 0}, '{OP_WBRAND, 3, 0}, '{OP_REDIR, 0, 4}, '{OP_WBALL, 0, 0},
        '{OP_DISP, 14, 0}, '{OP_WBALL, 0, 0}
    };

    logic                               clk = 1'b0;
    logic                               reset;
    logic [DISPATCH_WIDTH-1:0]          dispEn;
    robEntry [DISPATCH_WIDTH-1:0]       dispEntry;
    robIdx [DISPATCH_WIDTH-1:0]         dispIdx;
    logic [WB_WIDTH-1:0]                wbEn;
    robIdx [WB_WIDTH-1:0]               wbIdx;
    logic                               redirectEn;
    robIdx                              redirectIdx;
    logic [COMMIT_WIDTH-1:0]            commitEn;
    robEntry [COMMIT_WIDTH-1:0]         commitEntry;
    logic [COMMIT_WIDTH-1:0]            walkEn;
    robEntry [COMMIT_WIDTH-1:0]         walkEntry;
    logic                               walking;
    logic [CNT_W-1:0]                   creditReturn;

    // reference model of the buffer, oldest entry at the front
    robEntry    qEntry [$];
    robIdx      qIdx [$];
    bit         qDone [$];
    robIdx      expTail;
    int         credits;
    int         walkedNum;
    int         entrySeq;
    int         checks;
    int         errors;
    bit         aborted;
    logic [7:0] lfsr = 8'd80;

    robTop UUT (.*);

    always #5 clk = ~clk;

    // --------------------
    // helpers

    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};     // taps 8 6 5 4
    endfunction

    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic robEntry makeEntry(input int n);
        robEntry e;
        e.writesReg = n[0];
        e.archDest  = ARCH_REG_W'(n * 3 + 1);
        e.physDest  = PHYS_REG_W'(n + 7);
        return e;
    endfunction

    task automatic checkVal(input string name, input int expVal, input int actVal);
        checks++;
        assert (expVal == actVal) else begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic reportFault(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic timedOut(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        errors++;
        aborted = 1'b1;
    endtask

    // --------------------
    // output monitor

    always @(negedge clk) begin
        if (!reset) begin
            if (commitEn[1] && !commitEn[0]) reportFault("younger slot committed alone");
            if (walking && walkEn == '0) reportFault("walking high without a walk beat");
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (commitEn[i]) begin
                    checks++;
                    assert (qEntry.size() > 0) else reportFault("commit with an empty model");
                    if (qEntry.size() > 0) begin
                        assert (qDone[0]) else reportFault("entry committed before writeback");
                        checkVal("commitEntry", int'(qEntry[0]), int'(commitEntry[i]));
                        void'(qEntry.pop_front());
                        void'(qIdx.pop_front());
                        void'(qDone.pop_front());
                    end
                end
                if (walkEn[i]) begin
                    checks++;
                    assert (qEntry.size() > 0) else reportFault("walk with an empty model");
                    if (qEntry.size() > 0) begin
                        checkVal("walkEntry", int'(qEntry[$]), int'(walkEntry[i]));
                        void'(qEntry.pop_back());
                        void'(qIdx.pop_back());
                        void'(qDone.pop_back());
                        walkedNum++;
                    end
                end
            end
            credits = credits + int'(creditReturn);
        end
    end

    // --------------------
    // operations

    task automatic dispatchMany(input int total);
        int left;
        int n;
        int t;
        logic [DISPATCH_WIDTH-1:0] en;
        robEntry [DISPATCH_WIDTH-1:0] ents;
        left = total;
        while (left > 0 && !aborted) begin
            n = (left >= DISPATCH_WIDTH) ? DISPATCH_WIDTH : left;
            if (credits < n) begin
                @(posedge clk);
                dispEn <= '0;
                for (t = 0; t < TIMEOUT && credits < n; t++) @(negedge clk);
                if (credits < n) begin
                    timedOut("dispatch credits");
                    return;
                end
            end
            @(posedge clk);
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                en[s]   = s < n;
                ents[s] = makeEntry(entrySeq + s);
            end
            dispEn    <= en;
            dispEntry <= ents;
            @(negedge clk);
            checkVal("dispIdx[0]", int'(expTail), int'(dispIdx[0]));
            checkVal("dispIdx[1]", int'(robIdx'(PTR_W'(expTail) + PTR_W'(1))),
                     int'(dispIdx[1]));
            for (int s = 0; s < n; s++) begin
                qEntry.push_back(ents[s]);
                qIdx.push_back(robIdx'(PTR_W'(expTail) + PTR_W'(s)));
                qDone.push_back(1'b0);
            end
            expTail  = robIdx'(PTR_W'(expTail) + PTR_W'(n));
            credits  = credits - n;
            entrySeq = entrySeq + n;
            left     = left - n;
        end
        @(posedge clk);
        dispEn <= '0;
    endtask

    task automatic writebackRandom(input int count);
        int open [$];
        int pos;
        robIdx [WB_WIDTH-1:0] w;
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            open.delete();
            for (int j = 0; j < qDone.size(); j++) begin
                if (!qDone[j]) open.push_back(j);
            end
            if (open.size() == 0) begin
                wbEn <= '0;                         // nothing left to complete
                break;
            end
            pos       = open[randBits(4) % open.size()];
            w         = '0;
            w[k % 2]  = qIdx[pos];
            wbIdx     <= w;
            wbEn      <= WB_WIDTH'(1 << (k % 2));
            qDone[pos] = 1'b1;                      // marked when driven, seen by the DUT next edge
        end
        @(posedge clk);
        wbEn <= '0;
    endtask

    task automatic writebackAll();
        int t;
        writebackRandom(qDone.size());
        for (t = 0; t < TIMEOUT && qEntry.size() > 0; t++) @(negedge clk);
        if (qEntry.size() > 0) begin
            timedOut("the buffer to drain");
            return;
        end
        checkVal("held credits", ROB_SIZE, credits);
    endtask

    task automatic redirectAt(input int offset);
        int t;
        int squash;
        robIdx redIdx;
        @(posedge clk);
        if (offset >= qIdx.size()) begin
            reportFault("redirect offset beyond the buffered entries");
            return;
        end
        redIdx    = qIdx[offset];
        squash    = qIdx.size() - offset;
        walkedNum = 0;
        redirectEn  <= 1'b1;
        redirectIdx <= redIdx;
        @(posedge clk);
        redirectEn <= 1'b0;
        for (t = 0; t < TIMEOUT && !walking; t++) @(negedge clk);
        if (!walking) begin
            timedOut("walking to rise");
            return;
        end
        for (t = 0; t < TIMEOUT && walking; t++) @(negedge clk);
        if (walking) begin
            timedOut("walking to fall");
            return;
        end
        checkVal("walked entries", squash, walkedNum);
        expTail = redIdx;                           // the next dispatch reuses this index
    endtask

    // --------------------
    // main sequence

    initial begin
        reset       = 1'b1;
        dispEn      = '0;
        dispEntry   = '0;
        wbEn        = '0;
        wbIdx       = '0;
        redirectEn  = 1'b0;
        redirectIdx = '0;
        expTail     = '0;
        credits     = ROB_SIZE;
        entrySeq    = 0;
        checks      = 0;
        errors      = 0;
        aborted     = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkVal("commitEn", 0, int'(commitEn));
        checkVal("walkEn", 0, int'(walkEn));
        checkVal("walking", 0, int'(walking));
        checkVal("creditReturn", 0, int'(creditReturn));
        checkVal("dispIdx[0]", 0, int'(dispIdx[0]));
        $display("test reset finished, %0d errors so far", errors);

        for (int r = 0; r < NUM_STEPS && !aborted; r++) begin
            case (STEPS[r].op)
                OP_DISP:   dispatchMany(STEPS[r].count);
                OP_WBRAND: writebackRandom(STEPS[r].count);
                OP_WBALL:  writebackAll();
                OP_REDIR:  redirectAt(STEPS[r].offset);
                default: begin
                    repeat (STEPS[r].count) @(negedge clk);
                    checkVal("held credits", ROB_SIZE - qEntry.size(), credits);
                end
            endcase
            $display("test %0d op %0d finished, %0d errors so far", r, STEPS[r].op, errors);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
design/robPkg.sv
design/robIf.sv
design/robEntryRam.sv
design/robCompletionTable.sv
design/robCommitSelect.sv
design/robControl.sv
design/robTop.sv
test/robTop_props.sv
test/robTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := robTb
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
